/* Makefile */
LOG = sim.log
RTL = $(filter hdl/%,$(shell cat src.f))

.PHONY: all run lint clean

all: run

run: obj_dir/Vigr_switch_tb
	./obj_dir/Vigr_switch_tb | tee $(LOG)
	grep -q "ALL CHECKS PASSED" $(LOG)

obj_dir/Vigr_switch_tb: src.f $(wildcard hdl/*.sv tb/*.sv)
	verilator --binary --timing --assert --top-module igr_switch_tb \
		-f src.f -o Vigr_switch_tb

lint:
	verilator --lint-only -Wall --top-module igr_switch $(RTL)

clean:
	rm -rf obj_dir $(LOG)

/* hdl/axis_pkt_arb.sv */
`default_nettype none
`timescale 1ns/1ns

module axis_pkt_arb (
    input  logic              core_clk,
    input  logic              core_rstn,

    input  logic [1:0]        in_valid,
    input  igr_pkg::igr_beat_t in_data [2],
    output logic [1:0]        in_ready,

    output logic              out_valid,
    output igr_pkg::igr_beat_t out_data,
    input  logic              out_ready
);

    logic locked;
    logic grant;
    logic grant_q;

    // last grant doubles as the locked input while a packet is open
    always_comb begin
        if (locked) begin
            grant = grant_q;
        end else if (in_valid[0] && in_valid[1]) begin
            grant = ~grant_q;
        end else begin
            grant = in_valid[1];
        end
    end

    assign out_valid = in_valid[grant];
    assign out_data  = in_data[grant];

    always_comb begin
        in_ready        = 2'b00;
        in_ready[grant] = out_ready;
    end

    always_ff @(posedge core_clk) begin
        if (!core_rstn) begin
            locked  <= 1'b0;
            grant_q <= 1'b1;
        end else if (out_valid) begin
            grant_q <= grant;
            // a presented beat locks the grant, even if it stalls
            if (out_ready && out_data.beat.tlast) begin
                locked <= 1'b0;
            end else begin
                locked <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/axis_slice.sv */
`default_nettype none
`timescale 1ns/1ns

module axis_slice #(
    parameter type payload_t = logic [7:0]
) (
    input  logic     core_clk,
    input  logic     core_rstn,

    input  logic     in_valid,
    input  payload_t in_data,
    output logic     in_ready,

    output logic     out_valid,
    output payload_t out_data,
    input  logic     out_ready
);

    logic     main_valid;
    logic     skid_valid;
    payload_t main_data;
    payload_t skid_data;

    logic     main_load;

    // main register frees up this cycle
    assign main_load = out_ready || !main_valid;

    assign in_ready  = !skid_valid;
    assign out_valid = main_valid;
    assign out_data  = main_data;

    always_ff @(posedge core_clk) begin
        if (!core_rstn) begin
            main_valid <= 1'b0;
            skid_valid <= 1'b0;
        end else if (main_load) begin
            main_valid <= skid_valid || in_valid;
            skid_valid <= 1'b0;
        end else if (in_valid && in_ready) begin
            skid_valid <= 1'b1;
        end
    end

    always_ff @(posedge core_clk) begin
        if (main_load) begin
            main_data <= skid_valid ? skid_data : in_data;
        end
        // catch the beat that arrives while output stalls
        if (!main_load && in_ready) begin
            skid_data <= in_data;
        end
    end

endmodule

`default_nettype wire

/* hdl/igr_pkg.sv */
`default_nettype none

package igr_pkg;

    localparam int DATA_BYTES   = 8;
    localparam int DATA_WID     = DATA_BYTES * 8;
    localparam int TID_WID      = 2;

    // register port
    localparam int REG_ADDR_WID = 3;
    localparam int REG_DATA_WID = 2;
    localparam int NUM_SRC_MAX  = 4;

    localparam logic [REG_ADDR_WID-1:0] PAUSE_ADDR = 3'd4;

    typedef enum logic [1:0] {
        IGR_APP    = 2'd0,
        IGR_BYPASS = 2'd1,
        IGR_DROP   = 2'd2
    } igr_dest_t;

    typedef struct packed {
        logic [DATA_WID-1:0]   tdata;
        logic [DATA_BYTES-1:0] tkeep;
        logic                  tlast;
        logic [TID_WID-1:0]    tid;
        logic [0:0]            tuser;
    } axis_beat_t;

    // beat plus the destination picked at packet start
    typedef struct packed {
        axis_beat_t beat;
        igr_dest_t  dest;
    } igr_beat_t;

endpackage

`default_nettype wire

/* hdl/igr_port_path.sv */
`default_nettype none
`timescale 1ns/1ns

module igr_port_path (
    input  logic                core_clk,
    input  logic                core_rstn,

    input  logic                cmac_valid,
    input  igr_pkg::axis_beat_t cmac_data,
    output logic                cmac_ready,

    input  logic                host_valid,
    input  igr_pkg::axis_beat_t host_data,
    output logic                host_ready,

    input  igr_pkg::igr_dest_t  cmac_sel,
    input  igr_pkg::igr_dest_t  host_sel,
    input  logic                pause,

    output logic                app_valid,
    output igr_pkg::axis_beat_t app_data,
    input  logic                app_ready,

    output logic                byp_valid,
    output igr_pkg::axis_beat_t byp_data,
    input  logic                byp_ready
);

    logic [1:0]          src_valid;
    logic [1:0]          src_ready;
    igr_pkg::axis_beat_t src_data [2];
    igr_pkg::igr_dest_t  src_sel  [2];

    logic [1:0]          arb_valid;
    logic [1:0]          arb_ready;
    igr_pkg::axis_beat_t slc_data [2];
    igr_pkg::igr_beat_t  arb_data [2];

    logic                mrg_valid;
    logic                mrg_ready;
    igr_pkg::igr_beat_t  mrg_data;
    logic                to_app;

    logic                app_in_ready;
    logic                byp_in_ready;
    logic                byp_slc_valid;
    igr_pkg::igr_beat_t  app_q;
    igr_pkg::igr_beat_t  byp_q;

    // source 0 is cmac, source 1 is host
    assign src_valid   = {host_valid, cmac_valid};
    assign src_data[0] = cmac_data;
    assign src_data[1] = host_data;
    assign src_sel[0]  = cmac_sel;
    assign src_sel[1]  = host_sel;
    assign cmac_ready  = src_ready[0];
    assign host_ready  = src_ready[1];

    for (genvar s = 0; s < 2; s++) begin : g_src
        logic               tag_held;
        igr_pkg::igr_dest_t tag_q;

        axis_slice #(.payload_t(igr_pkg::axis_beat_t)) in_slice_i (
            .core_clk  (core_clk),
            .core_rstn (core_rstn),
            .in_valid  (src_valid[s]),
            .in_data   (src_data[s]),
            .in_ready  (src_ready[s]),
            .out_valid (arb_valid[s]),
            .out_data  (slc_data[s]),
            .out_ready (arb_ready[s])
        );

        // select is latched on the first cycle a packet's head is presented
        always_ff @(posedge core_clk) begin
            if (!core_rstn) begin
                tag_held <= 1'b0;
                tag_q    <= igr_pkg::IGR_DROP;
            end else if (arb_valid[s] && arb_ready[s] && slc_data[s].tlast) begin
                tag_held <= 1'b0;
            end else if (arb_valid[s] && !tag_held) begin
                tag_held <= 1'b1;
                tag_q    <= src_sel[s];
            end
        end

        assign arb_data[s] = '{beat: slc_data[s], dest: tag_held ? tag_q : src_sel[s]};
    end

    axis_pkt_arb arb_i (
        .core_clk  (core_clk),
        .core_rstn (core_rstn),
        .in_valid  (arb_valid),
        .in_data   (arb_data),
        .in_ready  (arb_ready),
        .out_valid (mrg_valid),
        .out_data  (mrg_data),
        .out_ready (mrg_ready)
    );

    // bypass and drop both leave on the bypass side
    assign to_app    = (mrg_data.dest == igr_pkg::IGR_APP);
    assign mrg_ready = to_app ? app_in_ready : byp_in_ready;

    axis_slice #(.payload_t(igr_pkg::igr_beat_t)) app_slice_i (
        .core_clk  (core_clk),
        .core_rstn (core_rstn),
        .in_valid  (mrg_valid && to_app),
        .in_data   (mrg_data),
        .in_ready  (app_in_ready),
        .out_valid (app_valid),
        .out_data  (app_q),
        .out_ready (app_ready)
    );

    axis_slice #(.payload_t(igr_pkg::igr_beat_t)) byp_slice_i (
        .core_clk  (core_clk),
        .core_rstn (core_rstn),
        .in_valid  (mrg_valid && !to_app),
        .in_data   (mrg_data),
        .in_ready  (byp_in_ready),
        .out_valid (byp_slc_valid),
        .out_data  (byp_q),
        .out_ready (byp_ready && !pause)
    );

    // test pause holds bypass beats in the slice
    assign byp_valid = byp_slc_valid && !pause;

    always_comb begin
        app_data       = app_q.beat;
        app_data.tuser = 1'b0;
        app_data.tid   = igr_pkg::TID_WID'(app_q.beat.tid[0]);

        byp_data        = byp_q.beat;
        byp_data.tuser  = 1'b0;
        // upper tid bit flags a drop packet
        byp_data.tid[1] = (byp_q.dest == igr_pkg::IGR_DROP);
    end

endmodule

`default_nettype wire

/* hdl/igr_sel_regs.sv */
`default_nettype none
`timescale 1ns/1ns

module igr_sel_regs #(
    parameter int NUM_PORT = 2
) (
    input  logic                              core_clk,
    input  logic                              core_rstn,

    input  logic                              reg_wr,
    input  logic [igr_pkg::REG_ADDR_WID-1:0]  reg_addr,
    input  logic [igr_pkg::REG_DATA_WID-1:0]  reg_wdata,

    output igr_pkg::igr_dest_t                dest_sel [2*NUM_PORT],
    output logic                              pause
);

    igr_pkg::igr_dest_t sel_q [igr_pkg::NUM_SRC_MAX];
    igr_pkg::igr_dest_t wr_dest;

    // code 3 is undefined, treat as drop
    assign wr_dest = (reg_wdata == 2'd3) ? igr_pkg::IGR_DROP : igr_pkg::igr_dest_t'(reg_wdata);

    always_ff @(posedge core_clk) begin
        if (!core_rstn) begin
            for (int i = 0; i < igr_pkg::NUM_SRC_MAX; i++) begin
                sel_q[i] <= igr_pkg::IGR_DROP;
            end
            pause <= 1'b0;
        end else if (reg_wr) begin
            for (int i = 0; i < igr_pkg::NUM_SRC_MAX; i++) begin
                if (reg_addr == igr_pkg::REG_ADDR_WID'(i)) begin
                    sel_q[i] <= wr_dest;
                end
            end
            if (reg_addr == igr_pkg::PAUSE_ADDR) begin
                pause <= reg_wdata[0];
            end
        end
    end

    // cmac selects first, then host selects
    for (genvar p = 0; p < NUM_PORT; p++) begin : g_sel
        assign dest_sel[p]          = sel_q[p];
        assign dest_sel[NUM_PORT+p] = sel_q[2+p];
    end

endmodule

`default_nettype wire

/* hdl/igr_switch.sv */
`default_nettype none
`timescale 1ns/1ns

module igr_switch #(
    parameter int NUM_PORT = 2
) (
    input  logic                             core_clk,
    input  logic                             core_rstn,

    input  logic                             reg_wr,
    input  logic [igr_pkg::REG_ADDR_WID-1:0] reg_addr,
    input  logic [igr_pkg::REG_DATA_WID-1:0] reg_wdata,

    input  logic                             cmac_valid [NUM_PORT],
    input  igr_pkg::axis_beat_t              cmac_data  [NUM_PORT],
    output logic                             cmac_ready [NUM_PORT],

    input  logic                             host_valid [NUM_PORT],
    input  igr_pkg::axis_beat_t              host_data  [NUM_PORT],
    output logic                             host_ready [NUM_PORT],

    output logic                             app_valid  [NUM_PORT],
    output igr_pkg::axis_beat_t              app_data   [NUM_PORT],
    input  logic                             app_ready  [NUM_PORT],

    output logic                             byp_valid  [NUM_PORT],
    output igr_pkg::axis_beat_t              byp_data   [NUM_PORT],
    input  logic                             byp_ready  [NUM_PORT]
);

    igr_pkg::igr_dest_t dest_sel [2*NUM_PORT];
    logic               pause;

    igr_sel_regs #(.NUM_PORT(NUM_PORT)) sel_regs_i (
        .core_clk  (core_clk),
        .core_rstn (core_rstn),
        .reg_wr    (reg_wr),
        .reg_addr  (reg_addr),
        .reg_wdata (reg_wdata),
        .dest_sel  (dest_sel),
        .pause     (pause)
    );

    for (genvar p = 0; p < NUM_PORT; p++) begin : g_port
        igr_port_path port_i (
            .core_clk   (core_clk),
            .core_rstn  (core_rstn),
            .cmac_valid (cmac_valid[p]),
            .cmac_data  (cmac_data[p]),
            .cmac_ready (cmac_ready[p]),
            .host_valid (host_valid[p]),
            .host_data  (host_data[p]),
            .host_ready (host_ready[p]),
            .cmac_sel   (dest_sel[p]),
            .host_sel   (dest_sel[NUM_PORT+p]),
            .pause      (pause),
            .app_valid  (app_valid[p]),
            .app_data   (app_data[p]),
            .app_ready  (app_ready[p]),
            .byp_valid  (byp_valid[p]),
            .byp_data   (byp_data[p]),
            .byp_ready  (byp_ready[p])
        );
    end

endmodule

`default_nettype wire

/* src.f */
hdl/igr_pkg.sv
hdl/axis_slice.sv
hdl/axis_pkt_arb.sv
hdl/igr_sel_regs.sv
hdl/igr_port_path.sv
hdl/igr_switch.sv
tb/igr_switch_sva.sv
tb/igr_switch_tb.sv

/* tb/igr_switch_sva.sv */
`default_nettype none
`timescale 1ns/1ns

module igr_switch_sva #(
    parameter int NUM_PORT = 2
) (
    input logic                             core_clk,
    input logic                             core_rstn,
    input logic                             reg_wr,
    input logic [igr_pkg::REG_ADDR_WID-1:0] reg_addr,
    input logic [igr_pkg::REG_DATA_WID-1:0] reg_wdata,
    input logic                             pause,
    input logic                             app_valid [NUM_PORT],
    input igr_pkg::axis_beat_t              app_data  [NUM_PORT],
    input logic                             app_ready [NUM_PORT],
    input logic                             byp_valid [NUM_PORT],
    input igr_pkg::axis_beat_t              byp_data  [NUM_PORT],
    input logic                             byp_ready [NUM_PORT]
);

    logic pause_wr;

    // pause level as last written on the register port
    always_ff @(posedge core_clk) begin
        if (!core_rstn) begin
            pause_wr <= 1'b0;
        end else if (reg_wr && reg_addr == igr_pkg::PAUSE_ADDR) begin
            pause_wr <= reg_wdata[0];
        end
    end

    for (genvar p = 0; p < NUM_PORT; p++) begin : g_port
        app_hold: assert property (@(posedge core_clk) disable iff (!core_rstn)
            app_valid[p] && !app_ready[p] |=> app_valid[p] && $stable(app_data[p]))
            else $error("app port %0d dropped or changed a stalled beat", p);

        // pause may hide a stalled bypass beat
        byp_hold: assert property (@(posedge core_clk) disable iff (!core_rstn)
            byp_valid[p] && !byp_ready[p] |=> pause || (byp_valid[p] && $stable(byp_data[p])))
            else $error("bypass port %0d dropped or changed a stalled beat", p);

        rst_idle: assert property (@(posedge core_clk)
            !core_rstn |=> !app_valid[p] && !byp_valid[p])
            else $error("port %0d output valid during reset", p);

        pause_idle: assert property (@(posedge core_clk) disable iff (!core_rstn)
            pause_wr |-> !byp_valid[p])
            else $error("bypass port %0d valid while paused", p);
    end

endmodule

bind igr_switch igr_switch_sva #(.NUM_PORT(NUM_PORT)) sva_i (.*);

`default_nettype wire

/* tb/igr_switch_tb.sv */
`default_nettype none
`timescale 1ns/1ns

module igr_switch_tb;

    localparam int NUM_PORT   = 2;
    localparam int MAX_CYCLES = 4000;

    logic                             core_clk = 1'b0;
    logic                             core_rstn;
    logic                             reg_wr;
    logic [igr_pkg::REG_ADDR_WID-1:0] reg_addr;
    logic [igr_pkg::REG_DATA_WID-1:0] reg_wdata;

    logic                cmac_valid [NUM_PORT];
    igr_pkg::axis_beat_t cmac_data  [NUM_PORT];
    logic                cmac_ready [NUM_PORT];
    logic                host_valid [NUM_PORT];
    igr_pkg::axis_beat_t host_data  [NUM_PORT];
    logic                host_ready [NUM_PORT];
    logic                app_valid  [NUM_PORT];
    igr_pkg::axis_beat_t app_data   [NUM_PORT];
    logic                app_ready  [NUM_PORT];
    logic                byp_valid  [NUM_PORT];
    igr_pkg::axis_beat_t byp_data   [NUM_PORT];
    logic                byp_ready  [NUM_PORT];

    // expected beats, index is output*4 + port*2 + source
    igr_pkg::axis_beat_t exp_q [8][$];
    int open_src [4] = '{-1, -1, -1, -1};

    int          beat_errs   = 0;
    int          beat_checks = 0;
    int          idle_errs   = 0;
    int          idle_checks = 0;
    int          test_base   = 0;
    int          cycles      = 0;
    int          pkt_id      = 0;
    int          errs;
    bit          bp_done;

    igr_switch #(.NUM_PORT(NUM_PORT)) dut_i (.*);

    always #20 core_clk = ~core_clk;

    always @(posedge core_clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    task automatic check_beat(input igr_pkg::axis_beat_t exp,
                              input igr_pkg::axis_beat_t act,
                              input string where);
        beat_checks++;
        if (act !== exp) begin
            beat_errs++;
            $display("MISMATCH %0t %s: expected %h, got %h", $time, where, exp, act);
        end
    endtask

    task automatic check_idle(input logic valid, input string where);
        idle_checks++;
        if (valid !== 1'b0) begin
            idle_errs++;
            $display("MISMATCH %0t %s: valid is high, expected idle", $time, where);
        end
    endtask

    // source is read from the head beat, then held until tlast
    task automatic take_beat(input int o, input int p, input igr_pkg::axis_beat_t act);
        igr_pkg::axis_beat_t e;
        int src;
        int q;
        src = (open_src[o*2+p] >= 0) ? open_src[o*2+p] : int'(act.tdata[56]);
        q   = o*4 + p*2 + src;
        if (exp_q[q].size() == 0) begin
            beat_errs++;
            $display("unexpected beat at %0t on %s port %0d, nothing was sent there",
                     $time, (o == 1) ? "bypass" : "app", p);
        end else begin
            e = exp_q[q].pop_front();
            check_beat(e, act, $sformatf("%s port %0d source %0d",
                                         (o == 1) ? "bypass" : "app", p, src));
        end
        open_src[o*2+p] = act.tlast ? -1 : src;
    endtask

    always @(negedge core_clk) begin
        for (int p = 0; p < NUM_PORT; p++) begin
            if (app_valid[p] && app_ready[p]) begin
                take_beat(0, p, app_data[p]);
            end
            if (byp_valid[p] && byp_ready[p]) begin
                take_beat(1, p, byp_data[p]);
            end
        end
    end

    function automatic logic src_ready(input int p, input int s);
        return (s == 0) ? cmac_ready[p] : host_ready[p];
    endfunction

    function automatic bit queues_empty();
        for (int i = 0; i < 8; i++) begin
            if (exp_q[i].size() != 0) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    task automatic drive_beat(input int p, input int s, input logic vld,
                              input igr_pkg::axis_beat_t b);
        if (s == 0) begin
            cmac_valid[p] <= vld;
            cmac_data[p]  <= b;
        end else begin
            host_valid[p] <= vld;
            host_data[p]  <= b;
        end
    endtask

    task automatic write_reg(input logic [2:0] addr, input logic [1:0] data);
        @(posedge core_clk);
        reg_wr    <= 1'b1;
        reg_addr  <= addr;
        reg_wdata <= data;
        @(posedge core_clk);
        reg_wr    <= 1'b0;
    endtask

    // expected beat follows the routing and tid rules for the given dest
    task automatic send_pkt(input int p, input int s, input int len,
                            input igr_pkg::igr_dest_t dest);
        igr_pkg::axis_beat_t b;
        igr_pkg::axis_beat_t e;
        int o;
        o = (dest == igr_pkg::IGR_APP) ? 0 : 1;
        pkt_id++;
        for (int i = 0; i < len; i++) begin
            b.tdata = {8'(s), 8'(p), 16'(pkt_id), $urandom};
            b.tlast = (i == len - 1);
            b.tkeep = b.tlast ? (8'($urandom) | 8'h01) : 8'hff;
            b.tid   = 2'(p);
            b.tuser = 1'($urandom);
            e        = b;
            e.tuser  = 1'b0;
            e.tid[1] = (dest == igr_pkg::IGR_DROP);
            exp_q[o*4 + p*2 + s].push_back(e);
            @(posedge core_clk);
            drive_beat(p, s, 1'b1, b);
            @(negedge core_clk);
            while (!src_ready(p, s)) @(negedge core_clk);
        end
        @(posedge core_clk);
        drive_beat(p, s, 1'b0, b);
    endtask

    task automatic wait_drain();
        @(negedge core_clk);
        while (!queues_empty()) @(negedge core_clk);
        repeat (4) @(negedge core_clk);
    endtask

    task automatic report_test(input string name);
        errs = beat_errs + idle_errs;
        $display("test %-16s %s", name, (errs == test_base) ? "ok" : "failed");
        test_base = errs;
    endtask

    task automatic reset_default_route();
        fork
            send_pkt(0, 0, 3, igr_pkg::IGR_DROP);
            begin
                @(negedge core_clk);
                while (!queues_empty()) begin
                    check_idle(app_valid[0], "app port 0 with reset selects");
                    @(negedge core_clk);
                end
            end
        join
        wait_drain();
        report_test("reset_default");
    endtask

    task automatic app_routing();
        write_reg(3'd0, igr_pkg::IGR_APP);
        write_reg(3'd3, igr_pkg::IGR_APP);
        write_reg(3'd1, igr_pkg::IGR_BYPASS);
        write_reg(3'd2, igr_pkg::IGR_BYPASS);
        fork
            send_pkt(0, 0, 4, igr_pkg::IGR_APP);
            send_pkt(1, 1, 3, igr_pkg::IGR_APP);
            send_pkt(0, 1, 2, igr_pkg::IGR_BYPASS);
            send_pkt(1, 0, 5, igr_pkg::IGR_BYPASS);
        join
        wait_drain();
        report_test("app_routing");
    endtask

    // both port 1 sources onto app 1
    task automatic merge_integrity();
        write_reg(3'd1, igr_pkg::IGR_APP);
        fork
            repeat (5) send_pkt(1, 0, 1 + int'($urandom % 6), igr_pkg::IGR_APP);
            repeat (5) send_pkt(1, 1, 1 + int'($urandom % 6), igr_pkg::IGR_APP);
        join
        wait_drain();
        report_test("merge");
    endtask

    // host 0 bypass traffic shares port 0 with cmac 0 app traffic
    task automatic random_backpressure();
        bp_done = 1'b0;
        fork
            begin
                fork
                    repeat (4) send_pkt(0, 0, 1 + int'($urandom % 7), igr_pkg::IGR_APP);
                    repeat (4) send_pkt(1, 1, 1 + int'($urandom % 7), igr_pkg::IGR_APP);
                    repeat (3) send_pkt(0, 1, 1 + int'($urandom % 7), igr_pkg::IGR_BYPASS);
                join
                bp_done = 1'b1;
            end
            begin
                while (!bp_done) begin
                    @(posedge core_clk);
                    app_ready[0] <= 1'($urandom);
                    app_ready[1] <= 1'($urandom);
                    byp_ready[0] <= 1'($urandom);
                end
                @(posedge core_clk);
                app_ready[0] <= 1'b1;
                app_ready[1] <= 1'b1;
                byp_ready[0] <= 1'b1;
            end
        join
        wait_drain();
        report_test("backpressure");
    endtask

    // host 0 is bypass, host 1 stays on app
    task automatic pause_bypass();
        write_reg(igr_pkg::PAUSE_ADDR, 2'd1);
        fork
            begin
                send_pkt(0, 1, 3, igr_pkg::IGR_BYPASS);
                send_pkt(0, 1, 2, igr_pkg::IGR_BYPASS);
            end
            begin
                repeat (3) send_pkt(1, 1, 4, igr_pkg::IGR_APP);
                while (exp_q[3].size() != 0) begin
                    @(negedge core_clk);
                    check_idle(byp_valid[0], "bypass port 0 while paused");
                end
                repeat (10) begin
                    @(negedge core_clk);
                    check_idle(byp_valid[0], "bypass port 0 while paused");
                end
                write_reg(igr_pkg::PAUSE_ADDR, 2'd0);
            end
        join
        wait_drain();
        report_test("pause");
    endtask

    task automatic select_change_mid_pkt();
        fork
            send_pkt(1, 0, 6, igr_pkg::IGR_APP);
            begin
                @(negedge core_clk);
                while (!(cmac_valid[1] && cmac_ready[1])) @(negedge core_clk);
                repeat (2) @(posedge core_clk);
                write_reg(3'd1, igr_pkg::IGR_BYPASS);
            end
        join
        send_pkt(1, 0, 3, igr_pkg::IGR_BYPASS);
        wait_drain();
        report_test("select_change");
    endtask

    initial begin
        void'($urandom(3));
        core_rstn <= 1'b0;
        reg_wr    <= 1'b0;
        reg_addr  <= '0;
        reg_wdata <= '0;
        for (int p = 0; p < NUM_PORT; p++) begin
            cmac_valid[p] <= 1'b0;
            cmac_data[p]  <= '0;
            host_valid[p] <= 1'b0;
            host_data[p]  <= '0;
            app_ready[p]  <= 1'b1;
            byp_ready[p]  <= 1'b1;
        end
        repeat (16) @(posedge core_clk);
        core_rstn <= 1'b1;

        reset_default_route();
        app_routing();
        merge_integrity();
        random_backpressure();
        pause_bypass();
        select_change_mid_pkt();

        errs = beat_errs + idle_errs;
        $display("checks %0d, errors %0d", beat_checks + idle_checks, errs);
        if (errs == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
